// File: hw/mem_pkg.sv
/*
 * memory package
 * widths, vector types and load/store width codes shared by the
 * data and instruction memories, plus the default memory size
 */

`default_nettype none

package mem_pkg;

    // byte-address bits decoded by default (64 KiB)
    localparam int DEF_RAM_AW = 16;

    // data memory is split into this many byte-wide lanes
    localparam int NUM_LANES = 4;

    // request address as it comes from the core
    typedef logic [31:0] addr_t;

    // full data or instruction word
    typedef logic [31:0] word_t;

    // one lane's worth of data
    typedef logic [7:0] byte_t;

    // byte offset inside a word, also a lane number
    typedef logic [1:0] lane_sel_t;

    // funct3 field of a load or store
    typedef logic [2:0] funct3_t;

    // width codes, shared by loads and stores
    localparam funct3_t F3_B  = 3'd0;
    localparam funct3_t F3_H  = 3'd1;
    localparam funct3_t F3_W  = 3'd2;

    // unsigned loads only
    localparam funct3_t F3_BU = 3'd4;
    localparam funct3_t F3_HU = 3'd5;

endpackage

`default_nettype wire

// File: hw/lane_if.sv
/*
 * byte lane bundle
 * per-lane row address, write enable and data for the four
 * byte RAMs of the data memory
 */

`timescale 1ns/10ps
`default_nettype none

interface lane_if import mem_pkg::*; #(
    parameter int row_aw = 14
) ();

    logic  [NUM_LANES-1:0][row_aw-1:0] row;
    logic  [NUM_LANES-1:0]             we;
    byte_t [NUM_LANES-1:0]             wdata;
    // lane 3 sits in the top byte when read as a word
    byte_t [NUM_LANES-1:0]             rdata;

    modport store (output row, output we, output wdata);
    modport load  (input rdata);

endinterface

`default_nettype wire

// File: hw/byte_lane_ram.sv
/*
 * byte lane RAM
 * synchronous single-port byte array, read-before-write
 */

`timescale 1ns/10ps
`default_nettype none

module byte_lane_ram import mem_pkg::*; #(
    parameter int row_aw = 14
) (
    input  logic              clk,
    input  logic [row_aw-1:0] row,
    input  logic              we,
    input  byte_t             wdata,
    output byte_t             rdata
);

    byte_t mem [2**row_aw];

    // old contents come out when a write hits the same row
    always_ff @(posedge clk) begin
        if (we) begin
            mem[row] <= wdata;
        end
        rdata <= mem[row];
    end

endmodule

`default_nettype wire

// File: hw/access_steer.sv
/*
 * access steering
 * range check of a data request and routing of store bytes and row
 * addresses onto the four byte lanes, with carry into the next row
 */

`timescale 1ns/10ps
`default_nettype none

module access_steer import mem_pkg::*; #(
    parameter int ram_aw = DEF_RAM_AW
) (
    input  addr_t     addr,
    input  word_t     wdata,
    input  logic      write,
    input  logic      read,
    input  funct3_t   funct3,
    lane_if.store     lanes,
    output logic      fault_now,
    output logic      read_ok,
    output lane_sel_t offset
);

    logic [2:0]        nbytes;
    logic [32:0]       last_byte;
    logic              range_bad;
    logic              store_code;
    logic              store_en;
    logic [ram_aw-3:0] row_base;

    // access size in bytes, unsupported codes count as one byte
    always_comb begin
        case (funct3)
            F3_B, F3_BU: nbytes = 3'd1;
            F3_H, F3_HU: nbytes = 3'd2;
            F3_W:        nbytes = 3'd4;
            default:     nbytes = 3'd1;
        endcase
    end

    // only SB, SH and SW may write
    always_comb begin
        case (funct3)
            F3_B, F3_H, F3_W: store_code = 1'b1;
            default:          store_code = 1'b0;
        endcase
    end

    // one extra bit so the top of the 32-bit space cannot wrap
    assign last_byte = {1'b0, addr} + {30'b0, nbytes} - 33'd1;
    assign range_bad = |(last_byte >> ram_aw);

    assign fault_now = (read | write) & range_bad;
    assign read_ok   = read & ~range_bad;
    assign store_en  = write & store_code & ~range_bad;

    assign offset   = addr[1:0];
    assign row_base = addr[ram_aw-1:2];

    for (genvar j = 0; j < NUM_LANES; j++) begin : g_lane
        lane_sel_t pos;
        logic      wrap;

        // which byte of the access lands on this lane
        assign pos  = lane_sel_t'(j) - offset;
        // lanes below the offset hold the tail in the next row
        assign wrap = lane_sel_t'(j) < offset;

        assign lanes.row[j]   = row_base + {{(ram_aw-3){1'b0}}, wrap};
        assign lanes.wdata[j] = byte_t'(wdata >> {pos, 3'b000});
        assign lanes.we[j]    = store_en & ({1'b0, pos} < nbytes);
    end

endmodule

`default_nettype wire

// File: hw/load_align.sv
/*
 * load alignment
 * delays the request control by one cycle, then rotates the lane
 * bytes back into place and sign- or zero-extends by width code
 */

`timescale 1ns/10ps
`default_nettype none

module load_align import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    lane_if.load      lanes,
    input  logic      read_ok,
    input  logic      fault_now,
    input  lane_sel_t offset,
    input  funct3_t   funct3,
    output word_t     rdata,
    output logic      fault
);

    logic      read_ok_q;
    logic      fault_q;
    lane_sel_t offset_q;
    funct3_t   funct3_q;

    word_t       lane_word;
    logic [63:0] doubled;
    word_t       aligned;
    word_t       extended;

    // control travels alongside the lane RAM read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_ok_q <= 1'b0;
            fault_q   <= 1'b0;
            offset_q  <= '0;
            funct3_q  <= '0;
        end else begin
            read_ok_q <= read_ok;
            fault_q   <= fault_now;
            offset_q  <= offset;
            funct3_q  <= funct3;
        end
    end

    assign lane_word = lanes.rdata;

    // rotate right by offset bytes so byte 0 of the access lands low
    assign doubled = {lane_word, lane_word};
    assign aligned = word_t'(doubled >> {offset_q, 3'b000});

    always_comb begin
        case (funct3_q)
            F3_B:    extended = {{24{aligned[7]}}, aligned[7:0]};
            F3_BU:   extended = {24'b0, aligned[7:0]};
            F3_H:    extended = {{16{aligned[15]}}, aligned[15:0]};
            F3_HU:   extended = {16'b0, aligned[15:0]};
            F3_W:    extended = aligned;
            default: extended = '0;
        endcase
    end

    // nothing leaves the memory unless a clean read was issued
    assign rdata = read_ok_q ? extended : '0;
    assign fault = fault_q;

endmodule

`default_nettype wire

// File: hw/data_ram.sv
/*
 * data memory
 * byte-addressed RAM of four byte lanes, with misaligned access,
 * range fault and one cycle of load latency
 */

`timescale 1ns/10ps
`default_nettype none

module data_ram import mem_pkg::*; #(
    parameter int ram_aw = DEF_RAM_AW
) (
    input  logic    clk,
    input  logic    rst_n,
    input  addr_t   addr,
    input  word_t   wdata,
    input  logic    write,
    input  logic    read,
    input  funct3_t funct3,
    output word_t   rdata,
    output logic    fault
);

    logic      fault_now;
    logic      read_ok;
    lane_sel_t offset;

    lane_if #(.row_aw(ram_aw - 2)) lanes ();

    access_steer #(.ram_aw(ram_aw)) steer_i (
        .addr      (addr),
        .wdata     (wdata),
        .write     (write),
        .read      (read),
        .funct3    (funct3),
        .lanes     (lanes.store),
        .fault_now (fault_now),
        .read_ok   (read_ok),
        .offset    (offset)
    );

    // one RAM per byte lane
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane_ram
        byte_lane_ram #(.row_aw(ram_aw - 2)) lane_ram_i (
            .clk   (clk),
            .row   (lanes.row[i]),
            .we    (lanes.we[i]),
            .wdata (lanes.wdata[i]),
            .rdata (lanes.rdata[i])
        );
    end

    load_align align_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .lanes     (lanes.load),
        .read_ok   (read_ok),
        .fault_now (fault_now),
        .offset    (offset),
        .funct3    (funct3),
        .rdata     (rdata),
        .fault     (fault)
    );

endmodule

`default_nettype wire

// File: hw/instr_ram.sv
/*
 * instruction memory
 * one word per row, registered read, flush blanks the next fetch
 */

`timescale 1ns/10ps
`default_nettype none

module instr_ram import mem_pkg::*; #(
    parameter int ram_aw = DEF_RAM_AW
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              write,
    input  word_t             wdata,
    input  logic [ram_aw-3:0] addr,
    output word_t             rdata
);

    word_t mem [2**(ram_aw-2)];
    word_t fetch_q;
    logic  flush_q;

    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr] <= wdata;
        end
        fetch_q <= mem[addr];
    end

    // comes out of reset set, so the first fetch is blank
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flush_q <= 1'b1;
        end else begin
            flush_q <= flush;
        end
    end

    assign rdata = flush_q ? '0 : fetch_q;

endmodule

`default_nettype wire

// File: hw/mem_top.sv
/*
 * memory top
 * data memory and instruction memory side by side, plain ports
 */

`timescale 1ns/10ps
`default_nettype none

module mem_top import mem_pkg::*; #(
    parameter int ram_aw = DEF_RAM_AW
) (
    input  logic              clk,
    input  logic              rst_n,

    // data side
    input  addr_t             d_addr,
    input  word_t             d_wdata,
    input  logic              d_write,
    input  logic              d_read,
    input  funct3_t           d_funct3,
    output word_t             d_rdata,
    output logic              d_fault,

    // instruction side, word address
    input  logic              i_flush,
    input  logic              i_write,
    input  word_t             i_wdata,
    input  logic [ram_aw-3:0] i_addr,
    output word_t             i_rdata
);

    data_ram #(.ram_aw(ram_aw)) data_ram_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .addr   (d_addr),
        .wdata  (d_wdata),
        .write  (d_write),
        .read   (d_read),
        .funct3 (d_funct3),
        .rdata  (d_rdata),
        .fault  (d_fault)
    );

    instr_ram #(.ram_aw(ram_aw)) instr_ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (i_flush),
        .write (i_write),
        .wdata (i_wdata),
        .addr  (i_addr),
        .rdata (i_rdata)
    );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
/*
 * testbench clock and reset
 * free-running clock, reset held low for a set number of cycles
 */

`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int period       = 10,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/mem_sva.sv
/*
 * data memory assertions
 * output and fault rules of the data memory, bound into data_ram
 */

`timescale 1ns/10ps
`default_nettype none

module mem_sva import mem_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 read,
    input logic                 fault,
    input logic                 fault_now,
    input word_t                rdata,
    input logic [NUM_LANES-1:0] lane_we
);

    // watched by the testbench
    int fail_count = 0;

    // no load issued, so the next cycle carries no data
    idle_gives_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !read |=> rdata == '0)
    else begin
        fail_count++;
        $error("load data not zero after a cycle without read");
    end

    fault_gives_zero: assert property (@(posedge clk) disable iff (!rst_n)
        fault |-> rdata == '0)
    else begin
        fail_count++;
        $error("load data not zero while fault is high");
    end

    // an out-of-range store must not touch any lane
    fault_blocks_write: assert property (@(posedge clk) disable iff (!rst_n)
        fault_now |-> lane_we == '0)
    else begin
        fail_count++;
        $error("lane write enable set during a faulting access");
    end

endmodule

bind data_ram mem_sva sva_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .read      (read),
    .fault     (fault),
    .fault_now (fault_now),
    .rdata     (rdata),
    .lane_we   (lanes.we)
);

`default_nettype wire

// File: dv/mem_tb.sv
/*
 * memory testbench
 * random loads, stores and fetches against a byte-level model of the
 * data memory and a word model of the instruction memory
 */

`timescale 1ns/10ps
`default_nettype none

module mem_tb import mem_pkg::*;;

    localparam int RAM_AW      = 10;
    localparam int MEM_BYTES   = 2 ** RAM_AW;
    localparam int IWORDS      = 2 ** (RAM_AW - 2);
    localparam int N_RANDOM    = 2000;
    localparam int N_FAULT     = 256;
    localparam int N_TAIL      = 4;
    localparam int N_COLLIDE   = 64;
    localparam int N_FETCH     = 500;
    localparam int TOTAL_OPS   = 2 + 2 * IWORDS + N_RANDOM + N_FAULT + N_TAIL
                                 + N_COLLIDE + IWORDS + N_FETCH + 1;
    localparam int MAX_CYCLES  = 2 * (TOTAL_OPS + 4);

    logic              clk;
    logic              rst_n;
    addr_t             d_addr;
    word_t             d_wdata;
    logic              d_write;
    logic              d_read;
    funct3_t           d_funct3;
    word_t             d_rdata;
    logic              d_fault;
    logic              i_flush;
    logic              i_write;
    word_t             i_wdata;
    logic [RAM_AW-3:0] i_addr;
    word_t             i_rdata;

    // reference state
    byte_t       dmem [MEM_BYTES];
    word_t       imem [IWORDS];
    word_t       exp_d_rdata;
    logic        exp_d_fault;
    word_t       exp_i_rdata;
    logic [31:0] rng_state = 32'd45910;
    int          cycles = 0;

    tb_clk_gen #(.period(10), .reset_cycles(4)) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_top #(.ram_aw(RAM_AW)) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata),
        .d_write  (d_write),
        .d_read   (d_read),
        .d_funct3 (d_funct3),
        .d_rdata  (d_rdata),
        .d_fault  (d_fault),
        .i_flush  (i_flush),
        .i_write  (i_write),
        .i_wdata  (i_wdata),
        .i_addr   (i_addr),
        .i_rdata  (i_rdata)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic funct3_t load_code(input logic [31:0] r);
        case (r % 5)
            0:       return F3_B;
            1:       return F3_H;
            2:       return F3_W;
            3:       return F3_BU;
            default: return F3_HU;
        endcase
    endfunction

    function automatic funct3_t store_code(input logic [31:0] r);
        case (r % 3)
            0:       return F3_B;
            1:       return F3_H;
            default: return F3_W;
        endcase
    endfunction

    // size comes from the low two bits of the width code
    function automatic int access_size(input funct3_t f3);
        case (f3[1:0])
            2'd1:    return 2;
            2'd2:    return 4;
            default: return 1;
        endcase
    endfunction

    function automatic logic beyond_end(input logic [31:0] a, input int size);
        longint last;
        last = longint'(a) + longint'(size) - 1;
        return last > longint'(MEM_BYTES - 1);
    endfunction

    function automatic word_t model_load(input funct3_t f3, input logic [31:0] a);
        word_t raw;
        int    base;
        raw  = '0;
        base = int'(a);
        for (int k = 0; k < access_size(f3); k++) begin
            raw[8*k +: 8] = dmem[base + k];
        end
        case (f3)
            F3_B:    return {{24{raw[7]}}, raw[7:0]};
            F3_H:    return {{16{raw[15]}}, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    task automatic model_store(input logic [31:0] a, input word_t wd, input int size);
        int base;
        base = int'(a);
        for (int k = 0; k < size; k++) begin
            dmem[base + k] = wd[8*k +: 8];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // check last cycle's results, drive the next request, update model
    task automatic run_cycle(input logic wr, input logic rd, input funct3_t f3,
                             input logic [31:0] a, input word_t wd,
                             input logic ifl, input logic iwr,
                             input logic [RAM_AW-3:0] ia, input word_t iwd);
        int   size;
        logic bad;
        @(negedge clk);
        check_value("d_rdata", d_rdata, exp_d_rdata);
        check_value("d_fault", {31'b0, d_fault}, {31'b0, exp_d_fault});
        check_value("i_rdata", i_rdata, exp_i_rdata);
        d_write  = wr;
        d_read   = rd;
        d_funct3 = f3;
        d_addr   = a;
        d_wdata  = wd;
        i_flush  = ifl;
        i_write  = iwr;
        i_addr   = ia;
        i_wdata  = iwd;
        size = access_size(f3);
        bad  = (rd | wr) & beyond_end(a, size);
        exp_d_fault = bad;
        // load sees the contents from before this cycle's store
        exp_d_rdata = (rd && !bad) ? model_load(f3, a) : '0;
        if (wr && !bad) begin
            model_store(a, wd, size);
        end
        exp_i_rdata = ifl ? '0 : imem[ia];
        if (iwr) begin
            imem[ia] = iwd;
        end
    endtask

    task automatic data_op(input logic wr, input logic rd, input funct3_t f3,
                           input logic [31:0] a, input word_t wd);
        run_cycle(wr, rd, f3, a, wd, 1'b1, 1'b0, '0, '0);
    endtask

    task automatic instr_op(input logic ifl, input logic iwr,
                            input logic [RAM_AW-3:0] ia, input word_t iwd);
        run_cycle(1'b0, 1'b0, F3_B, '0, '0, ifl, iwr, ia, iwd);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // bound data memory assertions count their failures
    always @(posedge clk) begin
        if (dut_i.data_ram_i.sva_i.fail_count != 0) begin
            $display("an assertion on the data memory failed");
            $display("sim failed");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        logic [31:0] r;
        logic        is_store;
        funct3_t     f3;
        logic [31:0] a;
        int          size;
        d_addr      = '0;
        d_wdata     = '0;
        d_write     = 1'b0;
        d_read      = 1'b0;
        d_funct3    = F3_B;
        i_flush     = 1'b1;
        i_write     = 1'b0;
        i_wdata     = '0;
        i_addr      = '0;
        exp_d_rdata = '0;
        exp_d_fault = 1'b0;
        exp_i_rdata = '0;
        wait (rst_n === 1'b1);

        // outputs are zero straight out of reset
        data_op(1'b0, 1'b0, F3_B, '0, '0);
        data_op(1'b0, 1'b0, F3_B, '0, '0);

        for (int w = 0; w < IWORDS; w++) begin
            data_op(1'b1, 1'b0, F3_W, 32'(4 * w), next_rand());
        end
        for (int w = 0; w < IWORDS; w++) begin
            data_op(1'b0, 1'b1, F3_W, 32'(4 * w), '0);
        end

        // any width at any offset, row crossings included
        for (int n = 0; n < N_RANDOM; n++) begin
            r = next_rand();
            is_store = r[0];
            f3 = is_store ? store_code(next_rand()) : load_code(next_rand());
            size = access_size(f3);
            a = next_rand() % (MEM_BYTES - size + 1);
            data_op(is_store, !is_store, f3, a, next_rand());
        end

        // addresses around the top of memory, some anywhere in 32 bits
        for (int n = 0; n < N_FAULT; n++) begin
            r = next_rand();
            is_store = r[0];
            f3 = is_store ? store_code(next_rand()) : load_code(next_rand());
            if (r[3:1] == 3'd0) begin
                a = next_rand();
            end else begin
                a = 32'(MEM_BYTES - 8) + (next_rand() % 16);
            end
            data_op(is_store, !is_store, f3, a, next_rand());
        end
        for (int w = IWORDS - N_TAIL; w < IWORDS; w++) begin
            data_op(1'b0, 1'b1, F3_W, 32'(4 * w), '0);
        end

        // read and write at one address in the same cycle
        for (int n = 0; n < N_COLLIDE; n++) begin
            f3 = store_code(next_rand());
            size = access_size(f3);
            a = next_rand() % (MEM_BYTES - size + 1);
            data_op(1'b1, 1'b1, f3, a, next_rand());
        end

        for (int w = 0; w < IWORDS; w++) begin
            instr_op(1'b1, 1'b1, (RAM_AW - 2)'(w), next_rand());
        end
        for (int n = 0; n < N_FETCH; n++) begin
            r = next_rand();
            instr_op(r[1:0] == 2'b00, 1'b0, r[15:8], '0);
        end

        // one idle cycle to check the last request
        data_op(1'b0, 1'b0, F3_B, '0, '0);

        if (dut_i.data_ram_i.sva_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hw/mem_pkg.sv
hw/lane_if.sv
hw/byte_lane_ram.sv
hw/access_steer.sv
hw/load_align.sv
hw/data_ram.sv
hw/instr_ram.sv
hw/mem_top.sv
dv/tb_clk_gen.sv
dv/mem_sva.sv
dv/mem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the memory testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mem_tb -f project.f -o mem_sim

sim_out=$(./obj_dir/mem_sim 2>&1) || true
echo "$sim_out"

if grep -qx "sim passed" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
